/* dv/clk_rst_gen.sv */
// ----------------------------
// Clock and reset source for the testbench
// ----------------------------

`timescale 1ns/10ps

module clk_rst_gen #(
  parameter int unsigned PeriodNs    = 100,
  parameter int unsigned ResetCycles = 16
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin : clk_toggle
    clk_o = 1'b0;
    forever begin
      #(PeriodNs / 2) clk_o = ~clk_o;
    end
  end

  // Release lands between clock edges
  initial begin : rst_release
    rst_n_o = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    #(PeriodNs / 4) rst_n_o = 1'b1;
  end

endmodule

/* dv/noncomp_model.svh */
// ----------------------------
// Reference model of sign injection and min/max for the slice testbench
// Included inside the testbench module after the package imports
// ----------------------------

`ifndef NONCOMP_MODEL_SVH
`define NONCOMP_MODEL_SVH

// Quiet NaNs with sign 0, exponent all ones and top mantissa bit set
localparam logic [31:0] MODEL_QNAN32 = 32'h7FC0_0000;
localparam logic [15:0] MODEL_QNAN16 = 16'h7E00;

function automatic bit nan_of(fp_word_t x, bit wide);
  if (wide) begin
    return (x[30:23] == 8'hFF) && (x[22:0] != 23'h0);
  end
  return (x[14:10] == 5'h1F) && (x[9:0] != 10'h0);
endfunction

function automatic bit snan_of(fp_word_t x, bit wide);
  return nan_of(x, wide) && (wide ? !x[22] : !x[9]);
endfunction

// Unsigned key that sorts non-NaN values in total order
function automatic logic [31:0] order_key(fp_word_t x, bit wide);
  logic [31:0] v;
  v = wide ? x : {x[15:0], 16'h0};
  return v[31] ? ~v : (v | 32'h8000_0000);
endfunction

// One element, FP16 values sit in the low half; returns {nv, value}
function automatic logic [32:0] element_op(fp_word_t a, fp_word_t b, noncomp_op_e op, bit wide);
  fp_word_t res;
  bit       nv;
  bit       a_first;
  int       sp;
  sp  = wide ? 31 : 15;
  res = a;
  nv  = 1'b0;
  case (op)
    OP_SGNJ:  res[sp] = b[sp];
    OP_SGNJN: res[sp] = ~b[sp];
    OP_SGNJX: res[sp] = a[sp] ^ b[sp];
    default: begin
      nv      = snan_of(a, wide) || snan_of(b, wide);
      a_first = order_key(a, wide) < order_key(b, wide);
      if (nan_of(a, wide) && nan_of(b, wide)) begin
        res = wide ? MODEL_QNAN32 : {16'h0, MODEL_QNAN16};
      end else if (nan_of(a, wide)) begin
        res = b;
      end else if (nan_of(b, wide)) begin
        res = a;
      end else if (op == OP_MIN) begin
        res = a_first ? a : b;
      end else begin
        res = a_first ? b : a;
      end
    end
  endcase
  return {nv, res};
endfunction

function automatic slice_rsp_t expected_rsp(slice_req_t req);
  slice_rsp_t  rsp;
  fp_word_t    a;
  fp_word_t    b;
  logic [32:0] lo;
  logic [32:0] hi;
  rsp        = '0;
  rsp.tag    = req.tag;
  if (req.fmt == FMT_FP32) begin
    lo         = element_op(req.operand_a, req.operand_b, req.op, 1'b1);
    rsp.result = lo[31:0];
    rsp.status.nv = lo[32];
  end else if (req.vectorial) begin
    lo = element_op({16'h0, req.operand_a[15:0]}, {16'h0, req.operand_b[15:0]}, req.op, 1'b0);
    hi = element_op({16'h0, req.operand_a[31:16]}, {16'h0, req.operand_b[31:16]}, req.op, 1'b0);
    rsp.result    = {hi[15:0], lo[15:0]};
    rsp.status.nv = lo[32] | hi[32];
  end else begin
    // Badly boxed scalar inputs read as the quiet NaN
    a = (req.operand_a[31:16] == 16'hFFFF) ? {16'h0, req.operand_a[15:0]} : {16'h0, MODEL_QNAN16};
    b = (req.operand_b[31:16] == 16'hFFFF) ? {16'h0, req.operand_b[15:0]} : {16'h0, MODEL_QNAN16};
    lo            = element_op(a, b, req.op, 1'b0);
    rsp.result    = {16'hFFFF, lo[15:0]};
    rsp.status.nv = lo[32];
  end
  return rsp;
endfunction

`endif

/* dv/tb_noncomp_slice.sv */
// ----------------------------
// Testbench of the non-computational slice
// Random requests, a credit-returning receiver and an in-order scoreboard
// ----------------------------

`timescale 1ns/10ps

module tb_noncomp_slice;

  import fp_format_pkg::*;
  import slice_ctrl_pkg::*;

  localparam int unsigned NumPipeRegs  = 2;
  localparam int unsigned MaxCredits   = 4;
  localparam int unsigned NumTxns      = 2000;
  localparam int unsigned DriveDelayNs = 5;
  localparam int unsigned ResetLimit   = 100;
  localparam int unsigned CycleLimit   = 40000;
  localparam int unsigned StallLimit   = 200;

  `include "noncomp_model.svh"

  logic       clk;
  logic       rst_n;
  logic       in_valid;
  slice_req_t req;
  logic       in_ready;
  logic       out_valid;
  slice_rsp_t rsp;
  logic       credit_return;

  // Expected responses with the cycle of their acceptance
  slice_rsp_t  exp_q [$];
  int unsigned cyc_q [$];

  logic [31:0] rng;
  int unsigned cycle;
  int unsigned sent;
  int unsigned received;
  int          credits;
  int unsigned held;
  int unsigned withhold;
  int unsigned stall;
  int unsigned ready_low_cycles;

  clk_rst_gen #(
    .PeriodNs    (100),
    .ResetCycles (16)
  ) i_clk_rst_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  noncomp_slice_top #(
    .NumPipeRegs (NumPipeRegs),
    .MaxCredits  (MaxCredits)
  ) i_dut (
    .clk_i           (clk),
    .rst_n_i         (rst_n),
    .in_valid_i      (in_valid),
    .req_i           (req),
    .in_ready_o      (in_ready),
    .out_valid_o     (out_valid),
    .rsp_o           (rsp),
    .credit_return_i (credit_return)
  );

  function automatic logic [31:0] xorshift32(logic [31:0] x);
    logic [31:0] s;
    s = x ^ (x << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  task automatic next_random(output logic [31:0] r);
    rng = xorshift32(rng);
    r   = rng;
  endtask

  task automatic report_mismatch(string name, logic [63:0] expected, logic [63:0] actual);
    $display("Error: %s expected %0h actual %0h", name, expected, actual);
    $display("TEST RESULT: FAIL");
    $fatal(1, "Stopped at the first mismatch");
  endtask

  task automatic report_failure(string what);
    $display("Error: %s", what);
    $display("TEST RESULT: FAIL");
    $fatal(1, "Stopped at the first failure");
  endtask

  // Special values are favored over plain random bit patterns
  function automatic fp_word_t pick_value(logic [31:0] r, bit wide);
    logic [15:0] h;
    if (wide) begin
      case (r[3:0])
        4'd0:    return {r[31], 31'h0};
        4'd1:    return {r[31], 8'hFF, 23'h0};
        4'd2:    return {r[31], 8'hFF, 1'b1, r[30:9]};
        4'd3:    return {r[31], 8'hFF, 1'b0, r[30:10], 1'b1};
        default: return r;
      endcase
    end
    case (r[3:0])
      4'd0:    h = {r[31], 15'h0};
      4'd1:    h = {r[31], 5'h1F, 10'h0};
      4'd2:    h = {r[31], 5'h1F, 1'b1, r[30:22]};
      4'd3:    h = {r[31], 5'h1F, 1'b0, r[30:23], 1'b1};
      default: h = r[31:16];
    endcase
    return {16'h0, h};
  endfunction

  task automatic build_operand(input fp_fmt_e fmt, input logic vec, output fp_word_t w);
    logic [31:0] lo;
    logic [31:0] hi;
    fp_word_t    lo_v;
    fp_word_t    hi_v;
    next_random(lo);
    next_random(hi);
    lo_v = pick_value(lo, fmt == FMT_FP32);
    hi_v = pick_value(hi, 1'b0);
    if (fmt == FMT_FP32) begin
      w = lo_v;
    end else if (vec) begin
      w = {hi_v[15:0], lo_v[15:0]};
    end else if (hi[7:6] == 2'b00) begin
      // Upper half left random, mostly not a valid box
      w = {hi[31:16], lo_v[15:0]};
    end else begin
      w = {16'hFFFF, lo_v[15:0]};
    end
  endtask

  task automatic build_request(output slice_req_t rq);
    logic [31:0] r;
    logic [2:0]  opc;
    fp_word_t    a;
    fp_word_t    b;
    next_random(r);
    opc          = 3'(r[10:3] % 8'd5);
    rq.fmt       = r[0] ? FMT_FP16 : FMT_FP32;
    rq.vectorial = r[1];
    rq.op        = noncomp_op_e'(opc);
    rq.tag       = r[15:12];
    build_operand(rq.fmt, rq.vectorial, a);
    build_operand(rq.fmt, rq.vectorial, b);
    rq.operand_a = a;
    rq.operand_b = b;
  endtask

  // Called right after a rising edge, before the DUT registers update
  task automatic sample_edge();
    slice_rsp_t  exp_rsp;
    int unsigned acc_cycle;
    assert (in_ready == (credits > 0))
      else report_mismatch("in_ready against credit count", 64'(credits > 0), 64'(in_ready));
    if (!in_ready) begin
      ready_low_cycles++;
      stall++;
    end else begin
      stall = 0;
    end
    assert (stall < StallLimit) else report_failure("in_ready_o stayed low for too long");
    if (in_valid && in_ready) begin
      exp_q.push_back(expected_rsp(req));
      cyc_q.push_back(cycle);
      sent++;
      credits--;
    end
    if (credit_return) begin
      credits++;
      held--;
    end
    if (out_valid) begin
      assert (exp_q.size() > 0) else report_failure("a response came with no request in flight");
      exp_rsp   = exp_q.pop_front();
      acc_cycle = cyc_q.pop_front();
      assert (cycle == acc_cycle + NumPipeRegs)
        else report_mismatch($sformatf("latency of response %0d", received),
                             64'(acc_cycle + NumPipeRegs), 64'(cycle));
      assert (rsp.result == exp_rsp.result)
        else report_mismatch($sformatf("result of response %0d", received),
                             {32'h0, exp_rsp.result}, {32'h0, rsp.result});
      assert (rsp.status == exp_rsp.status)
        else report_mismatch($sformatf("status of response %0d", received),
                             {59'h0, exp_rsp.status}, {59'h0, rsp.status});
      assert (rsp.tag == exp_rsp.tag)
        else report_mismatch($sformatf("tag of response %0d", received),
                             {60'h0, exp_rsp.tag}, {60'h0, rsp.tag});
      held++;
      received++;
      assert (held <= MaxCredits) else report_failure("receiver holds more responses than credits");
    end else if (cyc_q.size() > 0) begin
      assert (cycle < cyc_q[0] + NumPipeRegs) else report_failure("an expected response never came");
    end
  endtask

  // Called a short delay after the rising edge
  task automatic drive_inputs();
    logic [31:0] r;
    slice_req_t  rq;
    next_random(r);
    // Now and then the receiver keeps its credits long enough to drain them
    if (withhold == 0 && r[5:0] == 6'd0) begin
      withhold = 12;
    end
    credit_return = 1'b0;
    if (withhold > 0) begin
      withhold--;
    end else if (held > 0 && r[7:6] != 2'b00) begin
      credit_return = 1'b1;
    end
    in_valid = 1'b0;
    if (sent < NumTxns && in_ready && r[9:8] != 2'b00) begin
      build_request(rq);
      req      = rq;
      in_valid = 1'b1;
    end
  endtask

  initial begin : stimulus
    int unsigned wait_cnt;
    in_valid         = 1'b0;
    req              = '0;
    credit_return    = 1'b0;
    rng              = 32'd16;
    cycle            = 0;
    sent             = 0;
    received         = 0;
    credits          = MaxCredits;
    held             = 0;
    withhold         = 0;
    stall            = 0;
    ready_low_cycles = 0;

    wait_cnt = 0;
    while (rst_n !== 1'b1) begin
      @(posedge clk);
      wait_cnt++;
      assert (wait_cnt < ResetLimit) else report_failure("reset was never released");
    end

    // Quiet interface right after reset
    repeat (4) begin
      @(posedge clk);
      assert (!out_valid) else report_mismatch("out_valid_o after reset", 64'd0, 64'(out_valid));
      assert (in_ready) else report_mismatch("in_ready_o after reset", 64'd1, 64'(in_ready));
    end

    wait_cnt = 0;
    while (sent < NumTxns || exp_q.size() > 0 || held > 0) begin
      @(posedge clk);
      cycle++;
      sample_edge();
      wait_cnt++;
      assert (wait_cnt < CycleLimit) else report_failure("transactions did not finish in time");
      #(DriveDelayNs);
      drive_inputs();
    end

    @(posedge clk);
    assert (received == NumTxns)
      else report_mismatch("responses received", 64'(NumTxns), 64'(received));
    assert (in_ready && credits == MaxCredits) else report_failure("credits were not all restored");
    assert (ready_low_cycles > 0) else report_failure("in_ready_o never fell with credits held back");
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

/* list.f */
+incdir+dv
source/fp_format_pkg.sv
source/slice_ctrl_pkg.sv
source/operand_slicer.sv
source/noncomp_lane.sv
source/slice_packer.sv
source/credit_tracker.sv
source/noncomp_slice_top.sv
dv/clk_rst_gen.sv
dv/tb_noncomp_slice.sv

/* run.sh */
#!/bin/sh
# Compiles the slice testbench with Verilator and runs it
# The exit status of the simulation is the test result
set -e
cd "$(dirname "$0")"
verilator --binary --assert -Wno-fatal \
  --top-module tb_noncomp_slice \
  -f list.f \
  -o tb_noncomp_slice
./obj_dir/tb_noncomp_slice

/* source/credit_tracker.sv */
// ----------------------------
// Credit counter for the result buffer of the receiver
// ----------------------------

`timescale 1ns/10ps

module credit_tracker #(
  parameter int unsigned MaxCredits = 4
) (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic accept_i,
  input  logic credit_return_i,
  output logic in_ready_o
);

  localparam int unsigned CNT_WIDTH = $clog2(MaxCredits + 1);

  logic [CNT_WIDTH-1:0] credit_cnt_d;
  logic [CNT_WIDTH-1:0] credit_cnt_q;

  // A slot is reserved at issue and freed by the receiver
  always_comb begin : next_count
    credit_cnt_d = credit_cnt_q;
    if (accept_i && !credit_return_i) begin
      credit_cnt_d = credit_cnt_q - 1'b1;
    end else if (!accept_i && credit_return_i) begin
      credit_cnt_d = credit_cnt_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin : count_reg
    if (!rst_n_i) begin
      credit_cnt_q <= CNT_WIDTH'(MaxCredits);
    end else begin
      credit_cnt_q <= credit_cnt_d;
    end
  end

  assign in_ready_o = (credit_cnt_q != '0);

endmodule

/* source/fp_format_pkg.sv */
// ----------------------------
// Floating-point format definitions shared by the slice datapath
// Widths, canonical NaNs and the status flag layout
// ----------------------------

package fp_format_pkg;

  // ----------------------------
  // Widths
  // ----------------------------
  localparam int unsigned SLICE_WIDTH = 32;
  localparam int unsigned FP16_WIDTH  = 16;

  // One lane per FP16 element that fits in the slice
  localparam int unsigned NUM_LANES = SLICE_WIDTH / FP16_WIDTH;

  // Supported formats, FP32 uses lane 0 only
  typedef enum logic [0:0] {
    FMT_FP32 = 1'b0,
    FMT_FP16 = 1'b1
  } fp_fmt_e;

  typedef logic [SLICE_WIDTH-1:0] fp_word_t;
  typedef logic [FP16_WIDTH-1:0]  fp16_t;

  // IEEE 754 exception flags, same order as the RISC-V fflags
  typedef struct packed {
    logic nv;
    logic dz;
    logic of;
    logic uf;
    logic nx;
  } status_t;

  // ----------------------------
  // Canonical quiet NaNs
  // ----------------------------
  localparam fp_word_t CANON_NAN32 = 32'h7FC0_0000;
  localparam fp16_t    CANON_NAN16 = 16'h7E00;

endpackage

/* source/noncomp_lane.sv */
// ----------------------------
// One lane of sign injection and min/max with a fixed-depth pipeline
// FP32 is only handled when SupportsFp32 is set, else FP16 only
// ----------------------------

`timescale 1ns/10ps

module noncomp_lane #(
  parameter int unsigned NumPipeRegs  = 1,
  parameter bit          SupportsFp32 = 1'b1
) (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  slice_ctrl_pkg::lane_in_t   lane_i,
  input  slice_ctrl_pkg::lane_side_t side_i,
  output slice_ctrl_pkg::lane_out_t  lane_o,
  output slice_ctrl_pkg::lane_side_t side_o
);

  import fp_format_pkg::*;
  import slice_ctrl_pkg::*;

  // Sign, magnitude and NaN class of one operand
  typedef struct packed {
    logic        sign;
    logic [30:0] mag;
    logic        nan;
    logic        snan;
  } operand_info_t;

  function automatic operand_info_t decode(fp_word_t x, logic fp32);
    operand_info_t info;
    if (fp32) begin
      info.sign = x[31];
      info.mag  = x[30:0];
      info.nan  = (&x[30:23]) && (|x[22:0]);
      info.snan = info.nan && !x[22];
    end else begin
      info.sign = x[15];
      info.mag  = {16'b0, x[14:0]};
      info.nan  = (&x[14:10]) && (|x[9:0]);
      info.snan = info.nan && !x[9];
    end
    return info;
  endfunction

  logic          is_fp32;
  operand_info_t info_a;
  operand_info_t info_b;
  fp_word_t      word_a;
  fp_word_t      word_b;
  fp_word_t      canon_nan;
  logic          inj_sign;
  logic          a_lt_b;
  fp_word_t      result_d;
  status_t       status_d;

  // Pipeline, index 0 is the register right after the datapath
  logic [NumPipeRegs-1:0] valid_q;
  fp_word_t               result_q [0:NumPipeRegs-1];
  status_t                status_q [0:NumPipeRegs-1];
  lane_side_t             side_q   [0:NumPipeRegs-1];

  assign is_fp32 = SupportsFp32 && (lane_i.fmt == FMT_FP32);
  assign info_a  = decode(lane_i.a, is_fp32);
  assign info_b  = decode(lane_i.b, is_fp32);

  // FP16 values stay NaN-boxed inside the lane
  assign word_a    = is_fp32 ? lane_i.a : {{16{1'b1}}, lane_i.a[15:0]};
  assign word_b    = is_fp32 ? lane_i.b : {{16{1'b1}}, lane_i.b[15:0]};
  assign canon_nan = is_fp32 ? CANON_NAN32 : {{16{1'b1}}, CANON_NAN16};

  // ----------------------------
  // Datapath
  // ----------------------------
  always_comb begin : sign_inject
    case (lane_i.op)
      OP_SGNJN: inj_sign = ~info_b.sign;
      OP_SGNJX: inj_sign = info_a.sign ^ info_b.sign;
      default:  inj_sign = info_b.sign;
    endcase
  end

  // Total order on non-NaN values, -0 sorts below +0
  always_comb begin : order
    if (info_a.sign != info_b.sign) begin
      a_lt_b = info_a.sign;
    end else if (info_a.sign) begin
      a_lt_b = info_a.mag > info_b.mag;
    end else begin
      a_lt_b = info_a.mag < info_b.mag;
    end
  end

  always_comb begin : compute
    result_d = word_a;
    status_d = '0;
    case (lane_i.op)
      OP_SGNJ, OP_SGNJN, OP_SGNJX: begin
        if (is_fp32) begin
          result_d[31] = inj_sign;
        end else begin
          result_d[15] = inj_sign;
        end
      end
      OP_MIN, OP_MAX: begin
        status_d.nv = info_a.snan | info_b.snan;
        if (info_a.nan && info_b.nan) begin
          result_d = canon_nan;
        end else if (info_a.nan) begin
          result_d = word_b;
        end else if (info_b.nan) begin
          result_d = word_a;
        end else if ((lane_i.op == OP_MIN) == a_lt_b) begin
          result_d = word_a;
        end else begin
          result_d = word_b;
        end
      end
      default: begin
        result_d = word_a;
      end
    endcase
    // Idle lanes must not raise flags in the collapsed status
    if (!lane_i.valid) begin
      status_d = '0;
    end
  end

  // ----------------------------
  // Pipeline registers
  // ----------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin : valid_pipe
    if (!rst_n_i) begin
      valid_q <= '0;
    end else begin
      valid_q[0] <= lane_i.valid;
      for (int i = 1; i < NumPipeRegs; i++) begin
        valid_q[i] <= valid_q[i-1];
      end
    end
  end

  always_ff @(posedge clk_i) begin : data_pipe
    result_q[0] <= result_d;
    status_q[0] <= status_d;
    side_q[0]   <= side_i;
    for (int i = 1; i < NumPipeRegs; i++) begin
      result_q[i] <= result_q[i-1];
      status_q[i] <= status_q[i-1];
      side_q[i]   <= side_q[i-1];
    end
  end

  assign lane_o.valid  = valid_q[NumPipeRegs-1];
  assign lane_o.result = result_q[NumPipeRegs-1];
  assign lane_o.status = status_q[NumPipeRegs-1];
  assign side_o        = side_q[NumPipeRegs-1];

endmodule

/* source/noncomp_slice_top.sv */
// ----------------------------
// Non-computational FP slice, 32 bits wide with two FP16 lanes
// Accepts requests on valid/ready and returns results under credit control
// ----------------------------

`timescale 1ns/10ps

module noncomp_slice_top #(
  parameter int unsigned NumPipeRegs = 2,
  parameter int unsigned MaxCredits  = 4
) (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       in_valid_i,
  input  slice_ctrl_pkg::slice_req_t req_i,
  output logic                       in_ready_o,
  output logic                       out_valid_o,
  output slice_ctrl_pkg::slice_rsp_t rsp_o,
  input  logic                       credit_return_i
);

  import slice_ctrl_pkg::*;

  logic       accept;
  lane_in_t   lane0_in;
  lane_in_t   lane1_in;
  lane_side_t side_in;
  lane_out_t  lane0_out;
  lane_out_t  lane1_out;
  lane_side_t side_out;

  assign accept = in_valid_i & in_ready_o;

  operand_slicer i_operand_slicer (
    .req_i      (req_i),
    .in_valid_i (accept),
    .lane0_o    (lane0_in),
    .lane1_o    (lane1_in),
    .side_o     (side_in)
  );

  // ----------------------------
  // Lanes
  // ----------------------------
  noncomp_lane #(
    .NumPipeRegs  (NumPipeRegs),
    .SupportsFp32 (1'b1)
  ) i_lane0 (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .lane_i  (lane0_in),
    .side_i  (side_in),
    .lane_o  (lane0_out),
    .side_o  (side_out)
  );

  // Upper lane handles FP16 only, its sideband is not needed
  noncomp_lane #(
    .NumPipeRegs  (NumPipeRegs),
    .SupportsFp32 (1'b0)
  ) i_lane1 (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .lane_i  (lane1_in),
    .side_i  (side_in),
    .lane_o  (lane1_out),
    .side_o  ()
  );

  slice_packer i_slice_packer (
    .lane0_i     (lane0_out),
    .lane1_i     (lane1_out),
    .side_i      (side_out),
    .rsp_o       (rsp_o),
    .out_valid_o (out_valid_o)
  );

  credit_tracker #(
    .MaxCredits (MaxCredits)
  ) i_credit_tracker (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .accept_i        (accept),
    .credit_return_i (credit_return_i),
    .in_ready_o      (in_ready_o)
  );

endmodule

/* source/operand_slicer.sv */
// ----------------------------
// Splits an accepted request into the two lane inputs
// Scalar FP16 operands that are not NaN-boxed become canonical NaNs
// ----------------------------

`timescale 1ns/10ps

module operand_slicer (
  input  slice_ctrl_pkg::slice_req_t req_i,
  input  logic                       in_valid_i,
  output slice_ctrl_pkg::lane_in_t   lane0_o,
  output slice_ctrl_pkg::lane_in_t   lane1_o,
  output slice_ctrl_pkg::lane_side_t side_o
);

  import fp_format_pkg::*;

  logic fp16_scalar;
  logic a_boxed;
  logic b_boxed;

  assign fp16_scalar = (req_i.fmt == FMT_FP16) && !req_i.vectorial;

  // Upper half must be all ones for a valid boxed FP16 value
  assign a_boxed = &req_i.operand_a[SLICE_WIDTH-1:FP16_WIDTH];
  assign b_boxed = &req_i.operand_b[SLICE_WIDTH-1:FP16_WIDTH];

  // ----------------------------
  // Lane 0
  // ----------------------------
  always_comb begin : lane0_slice
    lane0_o.valid = in_valid_i;
    lane0_o.a     = req_i.operand_a;
    lane0_o.b     = req_i.operand_b;
    lane0_o.op    = req_i.op;
    lane0_o.fmt   = req_i.fmt;
    if (fp16_scalar && !a_boxed) begin
      lane0_o.a = {{FP16_WIDTH{1'b1}}, CANON_NAN16};
    end
    if (fp16_scalar && !b_boxed) begin
      lane0_o.b = {{FP16_WIDTH{1'b1}}, CANON_NAN16};
    end
  end

  // ----------------------------
  // Lane 1
  // ----------------------------
  // Upper FP16 halves, only active for vectorial FP16
  assign lane1_o.valid = in_valid_i && req_i.vectorial && (req_i.fmt == FMT_FP16);
  assign lane1_o.a     = req_i.operand_a >> FP16_WIDTH;
  assign lane1_o.b     = req_i.operand_b >> FP16_WIDTH;
  assign lane1_o.op    = req_i.op;
  assign lane1_o.fmt   = FMT_FP16;

  // Format, vector flag and tag follow lane 0 down the pipe
  assign side_o.fmt       = req_i.fmt;
  assign side_o.vectorial = req_i.vectorial;
  assign side_o.tag       = req_i.tag;

endmodule

/* source/slice_ctrl_pkg.sv */
// ----------------------------
// Control and transport types of the non-computational slice
// Requests, per-lane bundles and responses
// ----------------------------

package slice_ctrl_pkg;

  // Operations of the non-computational group
  typedef enum logic [2:0] {
    OP_SGNJ  = 3'd0,
    OP_SGNJN = 3'd1,
    OP_SGNJX = 3'd2,
    OP_MIN   = 3'd3,
    OP_MAX   = 3'd4
  } noncomp_op_e;

  typedef logic [3:0] tag_t;

  // Upstream request as accepted on the input handshake
  typedef struct packed {
    fp_format_pkg::fp_word_t operand_a;
    fp_format_pkg::fp_word_t operand_b;
    noncomp_op_e             op;
    fp_format_pkg::fp_fmt_e  fmt;
    logic                    vectorial;
    tag_t                    tag;
  } slice_req_t;

  // Operands of one lane, right-aligned
  typedef struct packed {
    logic                    valid;
    fp_format_pkg::fp_word_t a;
    fp_format_pkg::fp_word_t b;
    noncomp_op_e             op;
    fp_format_pkg::fp_fmt_e  fmt;
  } lane_in_t;

  // Sideband that travels with lane 0
  typedef struct packed {
    fp_format_pkg::fp_fmt_e fmt;
    logic                   vectorial;
    tag_t                   tag;
  } lane_side_t;

  typedef struct packed {
    logic                    valid;
    fp_format_pkg::fp_word_t result;
    fp_format_pkg::status_t  status;
  } lane_out_t;

  typedef struct packed {
    fp_format_pkg::fp_word_t result;
    fp_format_pkg::status_t  status;
    tag_t                    tag;
  } slice_rsp_t;

endpackage

/* source/slice_packer.sv */
// ----------------------------
// Builds the slice response from the lane results and the sideband
// ----------------------------

`timescale 1ns/10ps

module slice_packer (
  input  slice_ctrl_pkg::lane_out_t  lane0_i,
  input  slice_ctrl_pkg::lane_out_t  lane1_i,
  input  slice_ctrl_pkg::lane_side_t side_i,
  output slice_ctrl_pkg::slice_rsp_t rsp_o,
  output logic                       out_valid_o
);

  import fp_format_pkg::*;
  import slice_ctrl_pkg::*;

  lane_out_t lanes [0:NUM_LANES-1];

  assign lanes[0] = lane0_i;
  assign lanes[1] = lane1_i;

  // ----------------------------
  // Result assembly
  // ----------------------------
  always_comb begin : pack_result
    if (side_i.fmt == FMT_FP32) begin
      rsp_o.result = lane0_i.result;
    end else if (side_i.vectorial) begin
      rsp_o.result = {lane1_i.result[FP16_WIDTH-1:0], lane0_i.result[FP16_WIDTH-1:0]};
    end else begin
      // Scalar FP16 goes out NaN-boxed
      rsp_o.result = {{FP16_WIDTH{1'b1}}, lane0_i.result[FP16_WIDTH-1:0]};
    end
  end

  // Inactive lanes carry zero status, so a plain OR is enough
  always_comb begin : collapse_status
    status_t merged;
    merged = '0;
    for (int i = 0; i < NUM_LANES; i++) begin
      merged = merged | lanes[i].status;
    end
    rsp_o.status = merged;
  end

  assign rsp_o.tag   = side_i.tag;
  assign out_valid_o = lane0_i.valid;

endmodule
